/* hdl/ex_defines.svh */
// Execute stage parameters

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Integer data word
`define EX_XLEN 32

// Integer register file index, FP space not present
`define EX_RADDR_W 5

////////////////////////////////////////////////////////////
// Operator encodings
////////////////////////////////////////////////////////////

`define EX_ALU_OP_W 4
`define EX_MUL_OP_W 2

// High-word multiply consumes one half of operand B per step
`define EX_MULH_STEPS 2

`endif

/* hdl/ex_pkg.sv */
// Execute stage types

`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

  // Data word and register index
  typedef logic [`EX_XLEN-1:0]    word_t;
  typedef logic [`EX_RADDR_W-1:0] raddr_t;

  // ALU operations
  // Last four give only a compare bit, used by branches
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    EQ,
    NE,
    LTS,
    LTU
  } alu_op_e;

  // Multiplier operations
  // MUL is single cycle, the high-word ops are sequenced
  typedef enum logic [`EX_MUL_OP_W-1:0] {
    MUL,
    MULH,
    MULHU,
    MULHSU
  } mul_op_e;

endpackage

`default_nettype wire

/* hdl/ex_mul_if.sv */
// Multiplier request and response

`default_nettype none

interface ex_mul_if;

  // Request, held steady by the stage while ready is low
  logic             en;
  ex_pkg::mul_op_e  op;
  ex_pkg::word_t    op_a;
  ex_pkg::word_t    op_b;

  // Response, result valid when en and ready are both high
  ex_pkg::word_t    result;
  logic             ready;
  logic             multicycle;

  modport stage (output en, op, op_a, op_b, input result, ready, multicycle);

  modport unit (input en, op, op_a, op_b, output result, ready, multicycle);

endinterface

`default_nettype wire

/* hdl/ex_alu.sv */
// Integer ALU

`default_nettype none

`include "ex_defines.svh"

module ex_alu (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            en_i,
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o,
  output logic            ready_o
);

  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic [`EX_XLEN:0]  diff;
  logic               lt_u;
  logic               lt_s;
  logic               eq;
  word_t              res;
  logic               cmp;
  logic               ready_q;

  ////////////////////////////////////////////////////////////
  // Shared subtractor and comparators
  ////////////////////////////////////////////////////////////

  // Shift amount from the low bits of B
  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Extra MSB of the difference is the unsigned borrow
  assign diff = {1'b0, operand_a_i} - {1'b0, operand_b_i};
  assign lt_u = diff[`EX_XLEN];
  assign eq   = (operand_a_i == operand_b_i);

  // Differing signs decide directly, else unsigned order holds
  assign lt_s = (operand_a_i[`EX_XLEN-1] ^ operand_b_i[`EX_XLEN-1]) ?
                operand_a_i[`EX_XLEN-1] : lt_u;

  ////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////

  always_comb begin
    res = '0;
    cmp = 1'b0;
    case (operator_i)
      ADD:  res = operand_a_i + operand_b_i;
      SUB:  res = diff[`EX_XLEN-1:0];
      AND:  res = operand_a_i & operand_b_i;
      OR:   res = operand_a_i | operand_b_i;
      XOR:  res = operand_a_i ^ operand_b_i;
      SLL:  res = operand_a_i << shamt;
      SRL:  res = operand_a_i >> shamt;
      SRA:  res = word_t'($signed(operand_a_i) >>> shamt);
      // Compares return the flag on both outputs
      SLT, LTS: cmp = lt_s;
      SLTU, LTU: cmp = lt_u;
      EQ:   cmp = eq;
      NE:   cmp = ~eq;
      default: res = '0;
    endcase
    if (cmp) begin
      res = word_t'(1);
    end
  end

  // Result bus isolated when idle, compare bit left free for branches
  assign result_o     = en_i ? res : '0;
  assign cmp_result_o = cmp;

  // Ready rises one cycle after reset is released
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign ready_o = ready_q;

endmodule

`default_nettype wire

/* hdl/ex_mult.sv */
// Integer multiplier

`default_nettype none

`include "ex_defines.svh"

module ex_mult (
  input  logic clk,
  input  logic rst_n,
  ex_mul_if.unit mul
);

  import ex_pkg::*;

  localparam int STEPS   = `EX_MULH_STEPS;
  localparam int CNT_W   = $clog2(STEPS + 1);
  localparam int SLICE_W = `EX_XLEN / STEPS;

  logic                        is_high;
  logic                        sign_a;
  logic                        sign_b;
  logic [`EX_XLEN:0]           a_ext;
  logic [`EX_XLEN:0]           b_ext;
  logic [SLICE_W:0]            slice;
  logic signed [2*`EX_XLEN-1:0] partial;
  logic [2*`EX_XLEN-1:0]       acc_q;
  logic [CNT_W-1:0]            step_q;
  logic                        done;
  word_t                       low_prod;

  ////////////////////////////////////////////////////////////
  // Operand extension
  ////////////////////////////////////////////////////////////

  assign is_high = (mul.op != MUL);
  assign sign_a  = (mul.op == MULH) || (mul.op == MULHSU);
  assign sign_b  = (mul.op == MULH);

  // One extra bit so every high op is a signed product
  assign a_ext = {sign_a & mul.op_a[`EX_XLEN-1], mul.op_a};
  assign b_ext = {sign_b & mul.op_b[`EX_XLEN-1], mul.op_b};

  // Low word in a single cycle
  assign low_prod = word_t'(mul.op_a * mul.op_b);

  ////////////////////////////////////////////////////////////
  // High word sequencer
  ////////////////////////////////////////////////////////////

  // Lower slices are unsigned, top slice carries the sign of B
  always_comb begin
    if (step_q == CNT_W'(STEPS - 1)) begin
      slice = b_ext[`EX_XLEN -: (SLICE_W + 1)];
    end else begin
      slice = {1'b0, mul.op_b[step_q*SLICE_W +: SLICE_W]};
    end
  end

  assign partial = $signed(a_ext) * $signed(slice);
  assign done    = (step_q == CNT_W'(STEPS));

  // Counter advances per step, back to idle once accepted or dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (mul.en && is_high && !done) begin
      step_q <= step_q + 1'b1;
    end else begin
      step_q <= '0;
    end
  end

  // Partial products summed modulo 2^64, upper word stays exact
  always_ff @(posedge clk) begin
    if (mul.en && is_high && !done) begin
      if (step_q == '0) begin
        acc_q <= partial;
      end else begin
        acc_q <= acc_q + (partial << (step_q * SLICE_W));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////

  assign mul.result     = is_high ? acc_q[2*`EX_XLEN-1:`EX_XLEN] : low_prod;
  assign mul.ready      = !(mul.en && is_high) || done;
  // Busy past the first step
  assign mul.multicycle = (step_q != '0);

endmodule

`default_nettype wire

/* hdl/ex_writeback.sv */
// Execute stage write ports

`default_nettype none

module ex_writeback (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ex_valid_i,
  input  logic           alu_en_i,
  input  logic           mult_en_i,
  input  logic           csr_access_i,
  input  ex_pkg::word_t  alu_result_i,
  input  ex_pkg::word_t  mult_result_i,
  input  ex_pkg::word_t  csr_rdata_i,
  input  ex_pkg::word_t  lsu_rdata_i,
  input  logic           regfile_alu_we_i,
  input  ex_pkg::raddr_t regfile_alu_waddr_i,
  input  logic           regfile_we_i,
  input  ex_pkg::raddr_t regfile_waddr_i,
  input  logic           lsu_err_i,
  input  logic           wb_ready_i,
  output logic           regfile_alu_we_fw_o,
  output ex_pkg::raddr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t  regfile_alu_wdata_fw_o,
  output logic           regfile_we_wb_o,
  output ex_pkg::raddr_t regfile_waddr_wb_o,
  output ex_pkg::word_t  regfile_wdata_wb_o
);

  import ex_pkg::*;

  word_t  fw_wdata;
  logic   lsu_we;
  logic   we_q;
  raddr_t waddr_q;

  ////////////////////////////////////////////////////////////
  // ALU write port
  ////////////////////////////////////////////////////////////

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      fw_wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_wdata = alu_result_i;
    end else begin
      fw_wdata = '0;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wdata_fw_o = fw_wdata;

  ////////////////////////////////////////////////////////////
  // EX/WB register, LSU write port
  ////////////////////////////////////////////////////////////

  // Faulting loads never reach the register file
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  // Valid implies WB ready, flush only when WB moves on empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_q <= lsu_we;
    end else if (wb_ready_i) begin
      we_q <= 1'b0;
    end
  end

  // Destination tracks real writes only
  always_ff @(posedge clk) begin
    if (ex_valid_i && lsu_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
// Execute stage top level

`default_nettype none

module ex_stage (
  input  logic            clk,
  input  logic            rst_n,

  // ALU from ID
  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::word_t   alu_operand_a_i,
  input  ex_pkg::word_t   alu_operand_b_i,
  input  ex_pkg::word_t   alu_operand_c_i,
  input  logic            alu_en_i,

  // Multiplier from ID
  input  ex_pkg::mul_op_e mult_operator_i,
  input  ex_pkg::word_t   mult_operand_a_i,
  input  ex_pkg::word_t   mult_operand_b_i,
  input  logic            mult_en_i,
  output logic            mult_multicycle_o,

  // LSU
  input  logic            lsu_en_i,
  input  ex_pkg::word_t   lsu_rdata_i,
  input  logic            lsu_ready_ex_i,
  input  logic            lsu_err_i,

  // Write controls from ID
  input  logic            branch_in_ex_i,
  input  ex_pkg::raddr_t  regfile_alu_waddr_i,
  input  logic            regfile_alu_we_i,
  input  logic            regfile_we_i,
  input  ex_pkg::raddr_t  regfile_waddr_i,

  // CSR read data
  input  logic            csr_access_i,
  input  ex_pkg::word_t   csr_rdata_i,

  // LSU write port to WB
  output ex_pkg::raddr_t  regfile_waddr_wb_o,
  output logic            regfile_we_wb_o,
  output ex_pkg::word_t   regfile_wdata_wb_o,

  // Forwarding to ID and register file
  output ex_pkg::raddr_t  regfile_alu_waddr_fw_o,
  output logic            regfile_alu_we_fw_o,
  output ex_pkg::word_t   regfile_alu_wdata_fw_o,

  // Branch outputs to IF
  output ex_pkg::word_t   jump_target_o,
  output logic            branch_decision_o,

  // Stall control
  output logic            ex_ready_o,
  output logic            ex_valid_o,
  input  logic            wb_ready_i
);

  import ex_pkg::*;

  word_t alu_result;
  logic  alu_cmp_result;
  logic  alu_ready;
  logic  units_ready;

  ex_mul_if mul_if ();

  ////////////////////////////////////////////////////////////
  // ALU and branch outputs
  ////////////////////////////////////////////////////////////

  ex_alu u_ex_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (alu_en_i),
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result),
    .ready_o      (alu_ready)
  );

  // Target computed in ID, decision from the compare
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp_result;

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  assign mul_if.en   = mult_en_i;
  assign mul_if.op   = mult_operator_i;
  assign mul_if.op_a = mult_operand_a_i;
  assign mul_if.op_b = mult_operand_b_i;

  ex_mult u_ex_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .mul   (mul_if.unit)
  );

  assign mult_multicycle_o = mul_if.multicycle;

  ////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////

  ex_writeback u_ex_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .ex_valid_i             (ex_valid_o),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mul_if.result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Every unit and WB able to take the result
  assign units_ready = alu_ready & mul_if.ready & lsu_ready_ex_i & wb_ready_i;

  // Branches retire in EX, so they release ID on their own
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid flows right without waiting on ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

/* sim/ex_stage_tb.sv */
// Execute stage testbench

`default_nettype none

`include "ex_defines.svh"

module ex_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ex_pkg::*;

  localparam int unsigned SEED = 32'hca7a5152;
  localparam int N_ALU = 200;
  localparam int N_BR  = 60;
  localparam int N_MUL = 80;
  localparam int N_PRI = 40;
  localparam int N_BP  = 30;
  // Reset and test cycles plus multiply stalls and a margin
  localparam int MAX_CYCLES = 10 + N_ALU + N_BR + N_MUL * (`EX_MULH_STEPS + 2) +
                              2 * N_PRI + N_BP + 100;

  logic    clk = 1'b0;
  logic    rst_n;
  alu_op_e alu_operator;
  word_t   alu_a, alu_b, alu_c;
  logic    alu_en;
  mul_op_e mult_operator;
  word_t   mult_a, mult_b;
  logic    mult_en, mult_multicycle;
  logic    lsu_en, lsu_ready_ex, lsu_err;
  word_t   lsu_rdata;
  logic    branch_in_ex, regfile_alu_we, regfile_we;
  raddr_t  regfile_alu_waddr, regfile_waddr;
  logic    csr_access;
  word_t   csr_rdata;
  raddr_t  waddr_wb, waddr_fw;
  logic    we_wb, we_fw;
  word_t   wdata_wb, wdata_fw, jump_target;
  logic    branch_decision, ex_ready, ex_valid, wb_ready;

  // Expected values and check enables change on falling edges only
  logic    run_chk, fw_chk, valid_chk, br_chk, exp_br;
  word_t   exp_fw, exp_target;
  logic    exp_we;
  raddr_t  exp_waddr;
  int      errors = 0;
  int      checks = 0;
  int      cycles = 0;
  int unsigned seed;

  ex_stage u_ex_stage (
    .clk (clk), .rst_n (rst_n),
    .alu_operator_i (alu_operator), .alu_operand_a_i (alu_a),
    .alu_operand_b_i (alu_b), .alu_operand_c_i (alu_c), .alu_en_i (alu_en),
    .mult_operator_i (mult_operator), .mult_operand_a_i (mult_a),
    .mult_operand_b_i (mult_b), .mult_en_i (mult_en),
    .mult_multicycle_o (mult_multicycle),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata), .lsu_ready_ex_i (lsu_ready_ex),
    .lsu_err_i (lsu_err), .branch_in_ex_i (branch_in_ex),
    .regfile_alu_waddr_i (regfile_alu_waddr), .regfile_alu_we_i (regfile_alu_we),
    .regfile_we_i (regfile_we), .regfile_waddr_i (regfile_waddr),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .regfile_waddr_wb_o (waddr_wb), .regfile_we_wb_o (we_wb),
    .regfile_wdata_wb_o (wdata_wb), .regfile_alu_waddr_fw_o (waddr_fw),
    .regfile_alu_we_fw_o (we_fw), .regfile_alu_wdata_fw_o (wdata_fw),
    .jump_target_o (jump_target), .branch_decision_o (branch_decision),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid), .wb_ready_i (wb_ready)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
    word_t      r;
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ADD:       r = a + b;
      SUB:       r = a - b;
      AND:       r = a & b;
      OR:        r = a | b;
      XOR:       r = a ^ b;
      SLL:       r = a << sh;
      SRL:       r = a >> sh;
      SRA:       r = $signed(a) >>> sh;
      SLT, LTS:  r = {31'b0, $signed(a) < $signed(b)};
      SLTU, LTU: r = {31'b0, a < b};
      EQ:        r = {31'b0, a == b};
      NE:        r = {31'b0, a != b};
      default:   r = '0;
    endcase
    return r;
  endfunction

  // Operands extended to 64 bits by opcode
  // Product modulo 2^64 still holds the high word
  function automatic word_t ref_mul(input mul_op_e op, input word_t a, input word_t b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] prod;
    ax = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    bx = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = ax * bx;
    return (op == MUL) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process and EX/WB register model
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && run_chk) begin
      check("regfile_wdata_wb_o", wdata_wb, lsu_rdata);
      check("regfile_we_wb_o", we_wb, exp_we);
      if (exp_we) begin
        check("regfile_waddr_wb_o", waddr_wb, exp_waddr);
      end
      // Forwarding enable and address pass straight through
      check("regfile_alu_we_fw_o", we_fw, regfile_alu_we);
      check("regfile_alu_waddr_fw_o", waddr_fw, regfile_alu_waddr);
      if (fw_chk && ex_valid) begin
        check("regfile_alu_wdata_fw_o", wdata_fw, exp_fw);
      end
      // Only the LSU may hold back these cycles
      if (valid_chk) begin
        check("ex_valid_o", ex_valid, lsu_ready_ex);
        check("ex_ready_o", ex_ready, lsu_ready_ex);
      end
      if (br_chk) begin
        check("branch_decision_o", branch_decision, exp_br);
        check("jump_target_o", jump_target, exp_target);
        check("ex_ready_o", ex_ready, 1'b1);
      end
      // WB stall without a branch blocks both directions
      if (!wb_ready && !branch_in_ex) begin
        check("ex_ready_o", ex_ready, 1'b0);
        check("ex_valid_o", ex_valid, 1'b0);
      end
    end
    if (!rst_n) begin
      exp_we <= 1'b0;
    end else if (ex_valid) begin
      exp_we <= regfile_we & ~lsu_err;
      if (regfile_we && !lsu_err) begin
        exp_waddr <= regfile_waddr;
      end
    end else if (wb_ready) begin
      exp_we <= 1'b0;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic clear_enables();
    alu_en = 1'b0;
    mult_en = 1'b0;
    csr_access = 1'b0;
    branch_in_ex = 1'b0;
    fw_chk = 1'b0;
    valid_chk = 1'b0;
    br_chk = 1'b0;
  endtask

  // Side inputs that never change which result is expected
  task automatic randomize_side();
    lsu_en = $urandom_range(1);
    lsu_err = ($urandom_range(3) == 0);
    lsu_rdata = $urandom();
    regfile_we = $urandom_range(1);
    regfile_waddr = $urandom();
    regfile_alu_we = $urandom_range(1);
    regfile_alu_waddr = $urandom();
    csr_rdata = $urandom();
    alu_c = $urandom();
  endtask

  task automatic start_cycle();
    @(negedge clk);
    clear_enables();
    randomize_side();
    wb_ready = 1'b1;
    lsu_ready_ex = 1'b1;
  endtask

  task automatic random_alu_operands(input alu_op_e op);
    alu_operator = op;
    alu_a = $urandom();
    // Equal operands now and then so EQ and NE both resolve
    alu_b = ($urandom_range(3) == 0) ? alu_a : $urandom();
  endtask

  task automatic run_mul(input mul_op_e op, input logic with_alu);
    int   waited;
    logic seen_mc;
    logic seen_stall;
    waited = 0;
    seen_mc = 1'b0;
    seen_stall = 1'b0;
    start_cycle();
    mult_operator = op;
    mult_a = $urandom();
    mult_b = $urandom();
    mult_en = 1'b1;
    random_alu_operands(alu_op_e'($urandom_range(13)));
    alu_en = with_alu;
    exp_fw = ref_mul(op, mult_a, mult_b);
    fw_chk = 1'b1;
    // Operands stay put until the stage reports valid
    do begin
      @(posedge clk);
      if (!ex_valid) begin
        seen_mc = seen_mc | mult_multicycle;
      end
      seen_stall = seen_stall | ~ex_ready;
      waited++;
    end while (!ex_valid && waited < `EX_MULH_STEPS + 4);
    if (!ex_valid) begin
      errors++;
      $display("Multiply %s never produced a valid result", op.name());
    end
    if (op != MUL) begin
      check("mult_multicycle_o", seen_mc, 1'b1);
      check("ex_ready_o", seen_stall, 1'b1);
    end
  endtask

  initial begin
    seed = $urandom(SEED);
    rst_n = 1'b0;
    run_chk = 1'b0;
    clear_enables();
    randomize_side();
    wb_ready = 1'b1;
    lsu_ready_ex = 1'b1;
    alu_operator = ADD;
    alu_a = '0;
    alu_b = '0;
    mult_operator = MUL;
    mult_a = '0;
    mult_b = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // ALU ready comes up one edge later
    @(negedge clk);
    run_chk = 1'b1;

    // Random ALU traffic with the LSU stalling now and then
    repeat (N_ALU) begin
      start_cycle();
      random_alu_operands(alu_op_e'($urandom_range(13)));
      alu_en = 1'b1;
      lsu_ready_ex = ($urandom_range(7) != 0);
      exp_fw = ref_alu(alu_operator, alu_a, alu_b);
      fw_chk = 1'b1;
      valid_chk = 1'b1;
    end

    // Branch compares with WB sometimes stalled
    repeat (N_BR) begin
      start_cycle();
      random_alu_operands(alu_op_e'(EQ + $urandom_range(3)));
      branch_in_ex = 1'b1;
      alu_en = $urandom_range(1);
      wb_ready = $urandom_range(1);
      exp_fw = ref_alu(alu_operator, alu_a, alu_b);
      fw_chk = alu_en;
      exp_br = exp_fw[0];
      exp_target = alu_c;
      br_chk = 1'b1;
    end

    // Multiplies of every opcode
    repeat (N_MUL) begin
      run_mul(mul_op_e'($urandom_range(3)), 1'b0);
    end

    // CSR data and multiplier result both win over the ALU
    repeat (N_PRI) begin
      start_cycle();
      random_alu_operands(alu_op_e'($urandom_range(13)));
      alu_en = 1'b1;
      csr_access = 1'b1;
      exp_fw = csr_rdata;
      fw_chk = 1'b1;
      valid_chk = 1'b1;
      run_mul(MUL, 1'b1);
    end

    // Load a write into EX/WB and then stall WB
    start_cycle();
    random_alu_operands(ADD);
    alu_en = 1'b1;
    regfile_we = 1'b1;
    lsu_err = 1'b0;
    repeat (N_BP) begin
      start_cycle();
      random_alu_operands(alu_op_e'($urandom_range(13)));
      alu_en = 1'b1;
      wb_ready = 1'b0;
    end

    start_cycle();
    repeat (2) @(posedge clk);
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_mul_if.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
sim/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ex_pkg.sv
      - hdl/ex_mul_if.sv
      - hdl/ex_alu.sv
      - hdl/ex_mult.sv
      - hdl/ex_writeback.sv
      - hdl/ex_stage.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/ex_stage_tb.sv
